/* hdl/amac_config.svh */
`ifndef AMAC_CONFIG_SVH
`define AMAC_CONFIG_SVH

// operand width of the multiplier inputs
`define AMAC_OPW 16

// full product width, also the width of the saturated result
`define AMAC_PRODW 32

// accumulator width, needs at least one guard bit above the product
`define AMAC_ACCW 40

`endif

/* hdl/amac_pkg.sv */
`include "amac_config.svh"

package amac_pkg;

    // 2'b11 is not a legal opcode and leaves the accumulator alone
    typedef enum logic [1:0] {
        OP_CLR = 2'b00,
        OP_MUL = 2'b01,
        OP_MAC = 2'b10
    } mac_op_e;

    typedef struct packed {
        mac_op_e                      op;
        logic signed [`AMAC_OPW-1:0]  x;
        logic signed [`AMAC_OPW-1:0]  y;
    } mac_req_t;

    // acc is the accumulator clamped to the signed product range
    typedef struct packed {
        logic [`AMAC_PRODW-1:0]         prod;
        logic signed [`AMAC_PRODW-1:0]  acc;
        logic                           ovf;
    } mac_rsp_t;

endpackage

/* hdl/amac_top.sv */
`timescale 1ns/100ps

`include "amac_config.svh"

module amac_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                req_valid,
    input  amac_pkg::mac_req_t  req,
    output logic                rsp_valid,
    output amac_pkg::mac_rsp_t  rsp
);

    import amac_pkg::*;

    logic                   stage_valid;
    mac_op_e                stage_op;
    logic [`AMAC_PRODW-1:0] stage_prod;

    // first cycle registers the operands, the multiplier sits behind the register
    mul_stage u_stage (
        .clk         (clk),
        .arst_n      (arst_n),
        .req_valid   (req_valid),
        .req         (req),
        .stage_valid (stage_valid),
        .stage_op    (stage_op),
        .stage_prod  (stage_prod)
    );

    // second cycle updates the accumulator and registers the response
    mac_accum u_accum (
        .clk         (clk),
        .arst_n      (arst_n),
        .stage_valid (stage_valid),
        .stage_op    (stage_op),
        .stage_prod  (stage_prod),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp)
    );

endmodule

/* hdl/approx_mul16.sv */
`timescale 1ns/100ps

module approx_mul16 (
    input  logic signed [15:0] x,
    input  logic signed [15:0] y,
    output logic [31:0]        z
);

    // pp[r] is the Baugh-Wooley row for x[r], weight 2**r
    logic [15:0] pp [16];

    // compensation vectors that stand in for the low part of rows one to six
    logic [20:0] comp_a;
    logic [20:0] comp_b;
    logic [20:0] comp_c;
    logic [20:0] comp_d;

    // exact sum of rows seven to sixteen
    logic [31:0] row_sum;

    // the sign column of every row but the last one is inverted
    always_comb begin
        for (int r = 0; r < 15; r++) begin
            pp[r][14:0] = y[14:0] & {15{x[r]}};
            pp[r][15]   = ~(y[15] & x[r]);
        end
        pp[15][14:0] = ~(y[14:0] & {15{x[15]}});
        pp[15][15]   = y[15] & x[15];
    end

    // half adder style pairs taken from rows one to six
    always_comb begin
        comp_a = '0;
        comp_a[3]  = pp[2][1] ^ pp[3][0];
        comp_a[4]  = pp[2][1] & pp[3][0];
        comp_a[6]  = pp[4][1] & pp[5][0];
        comp_a[7]  = pp[0][7] ^ pp[1][6];
        comp_a[8]  = pp[0][7] & pp[1][6];
        comp_a[10] = pp[4][5] & pp[5][4];
        comp_a[12] = pp[0][11] & pp[1][10];
        comp_a[13] = pp[0][12] & pp[1][11];
        comp_a[14] = pp[4][10] ^ pp[5][9];
        comp_a[15] = pp[2][13] ^ pp[3][12];
        // the constant one of the first row is folded in with the row two sign bit
        comp_a[17] = pp[1][15];
        comp_a[18] = pp[2][15] & pp[3][14];
        comp_a[19] = pp[4][14] & pp[5][13];
        comp_a[20] = pp[4][15] & pp[5][14];
    end

    always_comb begin
        comp_b = '0;
        comp_b[7]  = pp[2][4] & pp[3][3];
        comp_b[13] = pp[2][10] & pp[3][9];
        comp_b[17] = ~pp[1][15];
        comp_b[18] = pp[3][15];
        comp_b[19] = pp[4][15] ^ pp[5][14];
        comp_b[20] = pp[5][15];
    end

    always_comb begin
        comp_c = '0;
        comp_c[7]  = pp[4][3] ^ pp[5][2];
        comp_c[17] = pp[2][15] ^ pp[3][14];
        comp_c[18] = pp[4][13] | pp[5][12];
    end

    always_comb begin
        comp_d = '0;
        comp_d[17] = pp[4][12] & pp[5][11];
        comp_d[18] = pp[4][14] ^ pp[5][13];
    end

    // bit 31 carries the constant one of the last row
    always_comb begin
        row_sum = 32'h8000_0000;
        for (int r = 6; r < 16; r++) begin
            row_sum = row_sum + ({16'b0, pp[r]} << r);
        end
    end

    // everything wraps modulo 2**32
    assign z = row_sum
             + {11'b0, comp_a}
             + {11'b0, comp_b}
             + {11'b0, comp_c}
             + {11'b0, comp_d};

endmodule

/* hdl/mac_accum.sv */
`timescale 1ns/100ps

`include "amac_config.svh"

module mac_accum (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    stage_valid,
    input  amac_pkg::mac_op_e       stage_op,
    input  logic [`AMAC_PRODW-1:0]  stage_prod,
    output logic                    rsp_valid,
    output amac_pkg::mac_rsp_t      rsp
);

    import amac_pkg::*;

    localparam int ACCW  = `AMAC_ACCW;
    localparam int PRODW = `AMAC_PRODW;

    // signed limits of the product range, extended to accumulator width
    localparam logic signed [ACCW-1:0] SAT_MAX = {{(ACCW-PRODW+1){1'b0}}, {(PRODW-1){1'b1}}};
    localparam logic signed [ACCW-1:0] SAT_MIN = {{(ACCW-PRODW+1){1'b1}}, {(PRODW-1){1'b0}}};

    logic signed [ACCW-1:0]  acc_q;
    logic signed [ACCW-1:0]  acc_next;
    logic signed [ACCW-1:0]  prod_ext;
    logic signed [PRODW-1:0] acc_sat;
    logic                    sat_hi;
    logic                    sat_lo;
    mac_rsp_t                rsp_q;
    logic                    valid_q;

    assign prod_ext = {{(ACCW-PRODW){stage_prod[PRODW-1]}}, stage_prod};

    always_comb begin
        case (stage_op)
            OP_CLR:  acc_next = '0;
            OP_MUL:  acc_next = prod_ext;
            OP_MAC:  acc_next = acc_q + prod_ext;
            default: acc_next = acc_q;
        endcase
    end

    // the clamp looks at the value the accumulator is about to take
    assign sat_hi  = acc_next > SAT_MAX;
    assign sat_lo  = acc_next < SAT_MIN;
    assign acc_sat = sat_hi ? SAT_MAX[PRODW-1:0] :
                     sat_lo ? SAT_MIN[PRODW-1:0] : acc_next[PRODW-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc_q   <= '0;
            rsp_q   <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= stage_valid;
            if (stage_valid) begin
                acc_q      <= acc_next;
                rsp_q.prod <= stage_prod;
                rsp_q.acc  <= acc_sat;
                rsp_q.ovf  <= sat_hi | sat_lo;
            end
        end
    end

    assign rsp_valid = valid_q;
    assign rsp       = rsp_q;

endmodule

/* hdl/mul_stage.sv */
`timescale 1ns/100ps

`include "amac_config.svh"

module mul_stage (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    req_valid,
    input  amac_pkg::mac_req_t      req,
    output logic                    stage_valid,
    output amac_pkg::mac_op_e       stage_op,
    output logic [`AMAC_PRODW-1:0]  stage_prod
);

    import amac_pkg::*;

    mac_req_t req_q;
    logic     valid_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_valid;
        end
    end

    // operands only move on a strobe and hold otherwise
    always_ff @(posedge clk) begin
        if (req_valid) begin
            req_q <= req;
        end
    end

    approx_mul16 u_mul (
        .x (req_q.x),
        .y (req_q.y),
        .z (stage_prod)
    );

    assign stage_valid = valid_q;
    assign stage_op    = req_q.op;

endmodule

/* run.sh */
#!/bin/sh
# builds and runs the testbench; the exit status is the simulator's
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module amac_tb \
    -f src.f \
    -o amac_sim

./obj_dir/amac_sim

/* src.f */
+incdir+hdl
hdl/amac_pkg.sv
hdl/approx_mul16.sv
hdl/mul_stage.sv
hdl/mac_accum.sv
hdl/amac_top.sv
tb/clk_gen.sv
tb/amac_checker.sv
tb/amac_tb.sv

/* tb/amac_checker.sv */
`timescale 1ns/100ps

module amac_checker (
    input logic               clk,
    input logic               arst_n,
    input logic               req_valid,
    input logic               rsp_valid,
    input amac_pkg::mac_rsp_t rsp
);

    import amac_pkg::*;

    // every strobe comes back exactly two edges later
    assert property (@(posedge clk) disable iff (!arst_n) $past(req_valid, 2) |-> rsp_valid)
        else $error("strobe was not answered two cycles later");

    // no pulse without a strobe two edges earlier
    assert property (@(posedge clk) disable iff (!arst_n) rsp_valid |-> $past(req_valid, 2))
        else $error("response pulse without a matching strobe");

    assert property (@(posedge clk) !arst_n |-> !rsp_valid)
        else $error("response pulse while in reset");

    // a saturated response sits on one of the two limits
    assert property (@(posedge clk) disable iff (!arst_n)
        (rsp_valid && rsp.ovf) |-> (rsp.acc == 32'sh7fff_ffff || rsp.acc == 32'sh8000_0000))
        else $error("overflow flag set while the result is not clamped");

endmodule

bind amac_top amac_checker u_checker (
    .clk       (clk),
    .arst_n    (arst_n),
    .req_valid (req_valid),
    .rsp_valid (rsp_valid),
    .rsp       (rsp)
);

/* tb/amac_tb.sv */
`timescale 1ns/100ps

`include "amac_config.svh"

module amac_tb;

    import amac_pkg::*;

    localparam int MAX_OPS   = 64;
    localparam int RST_CYCLES = 8;

    typedef struct packed {
        int      idx;
        int      strobe_cyc;
        mac_op_e op;
    } sent_t;

    logic     clk;
    logic     arst_n;
    logic     req_valid;
    mac_req_t req;
    logic     rsp_valid;
    mac_rsp_t rsp;

    // each word is op(4) x(16) y(16) expected product(32)
    logic [67:0] vecs [MAX_OPS];
    int          gaps [MAX_OPS];
    int          n_ops;
    int          n_checked;
    int          cyc;
    int          limit;
    integer      seed;
    sent_t       sent_q [$];

    logic signed [`AMAC_ACCW-1:0] model_acc;

    clk_gen u_clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    amac_top u_amac_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_rsp(input string name, input mac_rsp_t exp, input mac_rsp_t got);
        if (got !== exp) begin
            stop_with_failure($sformatf(
                "Mismatch %s: expected prod=%h acc=%h ovf=%b, actual prod=%h acc=%h ovf=%b",
                name, exp.prod, exp.acc, exp.ovf, got.prod, got.acc, got.ovf));
        end
    endtask

    task automatic check_op(input string name, input mac_op_e exp_op, input int exp_idx,
                            input mac_op_e got_op, input int got_idx);
        if (got_op !== exp_op || got_idx != exp_idx) begin
            stop_with_failure($sformatf("Mismatch %s: expected %s #%0d, actual %s #%0d",
                name, exp_op.name(), exp_idx, got_op.name(), got_idx));
        end
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (limit > 0 && cyc >= limit) begin
            stop_with_failure($sformatf("timeout after %0d cycles with %0d of %0d ops checked",
                cyc, n_checked, n_ops));
        end
    end

    // responses are sampled on the falling edge, half a cycle after they settle
    always @(negedge clk) begin
        sent_t                        ent;
        mac_rsp_t                     exp;
        mac_op_e                      exp_op;
        int                           exp_idx;
        logic [31:0]                  prod;
        longint                       acc_val;
        string                        name;
        if (arst_n && rsp_valid) begin
            // the operation due now is the one driven two edges earlier
            exp_idx = -1;
            foreach (sent_q[k]) begin
                if (sent_q[k].strobe_cyc == cyc - 2) begin
                    exp_idx = sent_q[k].idx;
                end
            end
            if (exp_idx < 0) begin
                stop_with_failure("response pulse without a strobe two cycles earlier");
            end
            ent    = sent_q.pop_front();
            exp_op = mac_op_e'(vecs[exp_idx][65:64]);
            prod   = vecs[n_checked][31:0];
            name   = $sformatf("op %0d (%s)", n_checked, exp_op.name());
            check_op(name, exp_op, exp_idx, ent.op, ent.idx);
            case (exp_op)
                OP_CLR:  model_acc = '0;
                OP_MUL:  model_acc = {{(`AMAC_ACCW-32){prod[31]}}, prod};
                default: model_acc = model_acc + {{(`AMAC_ACCW-32){prod[31]}}, prod};
            endcase
            acc_val  = longint'(model_acc);
            exp.prod = prod;
            exp.ovf  = 1'b1;
            if (acc_val > 64'sd2147483647) begin
                exp.acc = 32'h7fff_ffff;
            end else if (acc_val < -64'sd2147483648) begin
                exp.acc = 32'h8000_0000;
            end else begin
                exp.acc = model_acc[31:0];
                exp.ovf = 1'b0;
            end
            check_rsp(name, exp, rsp);
            n_checked = n_checked + 1;
        end
    end

    initial begin
        int r;
        int gap_sum;
        req_valid <= 1'b0;
        req       <= '0;
        cyc       <= 0;
        limit     = 0;
        n_ops     = 0;
        n_checked = 0;
        model_acc = '0;
        seed      = 32'h8cc6;
        gap_sum   = 0;
        for (int i = 0; i < MAX_OPS; i++) begin
            vecs[i] = '1;
        end
        $readmemh("tb/amac_testdata.txt", vecs);
        while (n_ops < MAX_OPS && vecs[n_ops][67:64] != 4'hf) begin
            n_ops = n_ops + 1;
        end
        if (n_ops == 0) begin
            stop_with_failure("no operations found in the test data file");
        end
        // half of the ops go back to back, the rest wait one or two cycles
        for (int i = 0; i < n_ops; i++) begin
            r       = $random(seed);
            gaps[i] = (r[1:0] < 2) ? 0 : int'(r[1:0]) - 1;
            gap_sum = gap_sum + gaps[i];
        end
        limit = 2 * (n_ops + gap_sum + RST_CYCLES) + 20;

        wait (arst_n === 1'b1);
        @(negedge clk);
        check_rsp("reset", '0, rsp);

        for (int i = 0; i < n_ops; i++) begin
            @(posedge clk);
            req_valid <= 1'b1;
            req.op    <= mac_op_e'(vecs[i][65:64]);
            req.x     <= vecs[i][63:48];
            req.y     <= vecs[i][47:32];
            sent_q.push_back('{idx: i, strobe_cyc: cyc + 1, op: mac_op_e'(vecs[i][65:64])});
            repeat (gaps[i]) begin
                @(posedge clk);
                req_valid <= 1'b0;
            end
        end
        @(posedge clk);
        req_valid <= 1'b0;

        wait (n_checked == n_ops);
        repeat (3) @(posedge clk);
        $display("** PASS **");
        $finish;
    end

endmodule

/* tb/amac_testdata.txt */
// columns: op(1 hex) x(4 hex) y(4 hex) expected approximate product(8 hex)
// op 0 is clear, 1 is multiply, 2 is multiply-accumulate
1_0040_0003_FFFF80C0
1_0040_0000_FFFF8000
1_0100_0200_00018000
1_7FC0_7FFF_3FDF0040
1_FFC0_0005_FFFF7EC0
1_0040_FFFF_FFFF7FC0
1_8000_0001_FFFF0000
1_F000_F000_00FF8000
1_1000_8000_F7FF8000
1_0C80_0064_00046200
// accumulate run on top of the last product
2_0040_0010_FFFF8400
2_0200_0100_00018000
2_FF00_0400_FFFB8000
2_0080_FF80_FFFF4000
2_0400_0400_000F8000
// clears in the middle of a run
0_0100_0003_FFFF8300
2_0040_0002_FFFF8080
2_0100_0100_00008000
2_2000_0010_00018000
0_0000_0000_FFFF8000
2_0040_0040_FFFF9000
// push past the positive limit, then back down past the negative one
0_0040_0001_FFFF8040
2_8000_8000_3FFF8000
2_8000_8000_3FFF8000
2_8000_8000_3FFF8000
2_8000_8000_3FFF8000
2_8000_7FFF_C0000000
2_8000_7FFF_C0000000
2_8000_7FFF_C0000000
2_8000_7FFF_C0000000
2_8000_7FFF_C0000000
2_8000_7FFF_C0000000
2_8000_7FFF_C0000000
2_8000_8000_3FFF8000
2_8000_8000_3FFF8000
2_8000_8000_3FFF8000
// mixed tail
1_7FC0_8000_C01F8000
1_FFC0_FFC0_FFFF9000
2_0040_7FFF_001F7FC0
1_0000_1234_FFFF8000

/* tb/clk_gen.sv */
`timescale 1ns/100ps

module clk_gen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset is held for eight rising edges and released on the last one
    initial begin
        arst_n = 1'b0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule
